/* common/periph_pkg.sv */
// Single hclk domain, 32-bit AHB data, 4-bit region field at addr[15:12], regions 2-15 unmapped
package periph_pkg;

  parameter int DATA_W     = 32;
  parameter int AHB_ADDR_W = 32;
  parameter int REGION_W   = 4;
  parameter int REGION_LSB = 12;

  parameter logic [REGION_W-1:0] REGION_TIMER = 4'd0;
  parameter logic [REGION_W-1:0] REGION_APB   = 4'd1;

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  typedef enum logic {
    HRESP_OKAY  = 1'b0,
    HRESP_ERROR = 1'b1
  } hresp_e;

  typedef enum logic [2:0] {
    BR_IDLE,
    BR_SETUP,
    BR_ACCESS,
    BR_ERR_FIRST,
    BR_ERR_LAST
  } bridge_state_e;

  // Timer register offsets within its region
  typedef enum logic [3:0] {
    TREG_CTRL   = 4'h0,
    TREG_VALUE  = 4'h4,
    TREG_RELOAD = 4'h8,
    TREG_STATUS = 4'hC
  } timer_reg_e;

  // ---------------------------------------------------------------------
  // Bus structs

  typedef struct packed {
    logic                  sel;
    logic [AHB_ADDR_W-1:0] addr;
    htrans_e               trans;
    logic                  write;
    logic [2:0]            size;
    logic                  ready_in;
  } ahb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              readyout;
    hresp_e            resp;
  } ahb_rsp_t;

  typedef struct packed {
    logic [31:0]       paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

endpackage

/* src/ahb_slave_mux.sv */
// Regions other than timer and APB get a two-cycle error; idle and busy transfers get zero-wait okay
module ahb_slave_mux import periph_pkg::*; (
  input  logic     hclk,
  input  logic     rst_n,
  input  ahb_req_t ahb_req,
  input  ahb_rsp_t timer_rsp,
  input  ahb_rsp_t apb_bridge_rsp,
  output logic     sel_timer,
  output logic     sel_apb,
  output ahb_rsp_t ahb_rsp
);

  logic [REGION_W-1:0] region;
  logic [REGION_W-1:0] dp_region;
  logic                dp_active;
  logic                dp_unmapped;
  logic                err_second;
  logic                accept;

  // ---------------------------------------------------------------------
  // Address phase decode

  assign region    = ahb_req.addr[REGION_LSB +: REGION_W];
  assign sel_timer = ahb_req.sel && (region == REGION_TIMER);
  assign sel_apb   = ahb_req.sel && (region == REGION_APB);
  assign accept    = ahb_req.sel && ahb_req.ready_in &&
                     (ahb_req.trans == HTRANS_NONSEQ || ahb_req.trans == HTRANS_SEQ);

  // Data phase tracking, frozen while the current slave stalls
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      dp_active <= 1'b0;
      dp_region <= '0;
    end else if (ahb_rsp.readyout) begin
      dp_active <= accept;
      dp_region <= region;
    end
  end

  assign dp_unmapped = dp_active && (dp_region != REGION_TIMER) && (dp_region != REGION_APB);

  // Default slave, second error cycle
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      err_second <= 1'b0;
    end else begin
      err_second <= dp_unmapped && !err_second;
    end
  end

  // ---------------------------------------------------------------------
  // Response return

  always_comb begin
    ahb_rsp.rdata    = '0;
    ahb_rsp.readyout = 1'b1;
    ahb_rsp.resp     = HRESP_OKAY;
    if (dp_active && dp_region == REGION_TIMER) begin
      ahb_rsp = timer_rsp;
    end else if (dp_active && dp_region == REGION_APB) begin
      ahb_rsp = apb_bridge_rsp;
    end else if (dp_unmapped) begin
      ahb_rsp.readyout = err_second;
      ahb_rsp.resp     = HRESP_ERROR;
    end
  end

endmodule

/* timer/ahb_timer.sv */
// Word access only, offset from addr[3:0] so the 4 registers alias through the region
module ahb_timer import periph_pkg::*; (
  input  logic              hclk,
  input  logic              rst_n,
  input  logic              sel_timer,
  input  ahb_req_t          ahb_req,
  input  logic [DATA_W-1:0] hwdata,
  output ahb_rsp_t          timer_rsp,
  output logic              timer_int
);

  logic              accept;
  logic              dp_valid;
  logic              dp_write;
  timer_reg_e        dp_off;
  logic              wr_en;
  logic              wrap;
  logic [1:0]        ctrl;
  logic [DATA_W-1:0] value;
  logic [DATA_W-1:0] reload;
  logic              int_flag;

  assign accept = sel_timer && ahb_req.ready_in &&
                  (ahb_req.trans == HTRANS_NONSEQ || ahb_req.trans == HTRANS_SEQ);

  // Address phase capture
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      dp_valid <= 1'b0;
      dp_write <= 1'b0;
      dp_off   <= TREG_CTRL;
    end else if (ahb_req.ready_in) begin
      dp_valid <= accept;
      dp_write <= ahb_req.write;
      dp_off   <= timer_reg_e'(ahb_req.addr[3:0]);
    end
  end

  assign wr_en = dp_valid && dp_write;
  assign wrap  = ctrl[0] && (value == '0) && !(wr_en && dp_off == TREG_VALUE);

  // ---------------------------------------------------------------------
  // Registers and counter

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl   <= 2'b00;
      reload <= '0;
    end else if (wr_en) begin
      if (dp_off == TREG_CTRL) begin
        ctrl <= hwdata[1:0];
      end
      if (dp_off == TREG_RELOAD) begin
        reload <= hwdata;
      end
    end
  end

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      value <= '0;
    end else if (wr_en && dp_off == TREG_VALUE) begin
      value <= hwdata;
    end else if (wrap) begin
      value <= reload;
    end else if (ctrl[0]) begin
      value <= value - 1'b1;
    end
  end

  // A wrap in the same cycle as a clear keeps the flag set
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      int_flag <= 1'b0;
    end else if (wrap) begin
      int_flag <= 1'b1;
    end else if (wr_en && dp_off == TREG_STATUS && hwdata[0]) begin
      int_flag <= 1'b0;
    end
  end

  assign timer_int = int_flag && ctrl[1];

  // Read data from the captured offset
  always_comb begin
    timer_rsp.readyout = 1'b1;
    timer_rsp.resp     = HRESP_OKAY;
    case (dp_off)
      TREG_CTRL:   timer_rsp.rdata = {{(DATA_W-2){1'b0}}, ctrl};
      TREG_VALUE:  timer_rsp.rdata = value;
      TREG_RELOAD: timer_rsp.rdata = reload;
      TREG_STATUS: timer_rsp.rdata = {{(DATA_W-1){1'b0}}, int_flag};
      default:     timer_rsp.rdata = '0;
    endcase
  end

endmodule

/* apb_bridge/ahb_apb_bridge.sv */
// One APB transfer per AHB transfer, at least 3 cycles; paddr carries only the low APB_ADDR_W bits
module ahb_apb_bridge import periph_pkg::*; #(
  parameter int APB_ADDR_W = 12
) (
  input  logic              hclk,
  input  logic              rst_n,
  input  logic              sel_apb,
  input  ahb_req_t          ahb_req,
  input  logic [DATA_W-1:0] hwdata,
  input  apb_rsp_t          apb_rsp,
  output ahb_rsp_t          apb_bridge_rsp,
  output apb_req_t          apb_req
);

  bridge_state_e           state;
  bridge_state_e           state_nxt;
  logic                    accept;
  logic [APB_ADDR_W-1:0]   paddr_q;
  logic                    pwrite_q;
  logic [DATA_W-1:0]       wdata_q;
  logic [DATA_W-1:0]       rdata_q;

  assign accept = sel_apb && ahb_req.ready_in &&
                  (ahb_req.trans == HTRANS_NONSEQ || ahb_req.trans == HTRANS_SEQ);

  // ---------------------------------------------------------------------
  // FSM

  always_comb begin
    state_nxt = state;
    case (state)
      BR_IDLE: begin
        if (accept) begin
          state_nxt = BR_SETUP;
        end
      end
      BR_SETUP: state_nxt = BR_ACCESS;
      BR_ACCESS: begin
        if (apb_rsp.pready) begin
          state_nxt = apb_rsp.pslverr ? BR_ERR_FIRST : BR_IDLE;
        end
      end
      BR_ERR_FIRST: state_nxt = BR_ERR_LAST;
      // Last error cycle has readyout high, so a new transfer may start
      BR_ERR_LAST: state_nxt = accept ? BR_SETUP : BR_IDLE;
      default: state_nxt = BR_IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= BR_IDLE;
      pwrite_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (accept) begin
        pwrite_q <= ahb_req.write;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Address, write data and read data capture

  always_ff @(posedge hclk) begin
    if (accept) begin
      paddr_q <= ahb_req.addr[APB_ADDR_W-1:0];
    end
    if (state == BR_SETUP) begin
      wdata_q <= hwdata;
    end
    if (state == BR_ACCESS && apb_rsp.pready) begin
      rdata_q <= apb_rsp.prdata;
    end
  end

  // APB side
  always_comb begin
    apb_req.paddr                 = '0;
    apb_req.paddr[APB_ADDR_W-1:0] = paddr_q;
    apb_req.psel                  = (state == BR_SETUP) || (state == BR_ACCESS);
    apb_req.penable               = (state == BR_ACCESS);
    apb_req.pwrite                = pwrite_q;
    // hwdata is live in setup and held in wdata_q for access
    apb_req.pwdata                = (state == BR_SETUP) ? hwdata : wdata_q;
  end

  // AHB side
  assign apb_bridge_rsp.rdata    = rdata_q;
  assign apb_bridge_rsp.readyout = (state == BR_IDLE) || (state == BR_ERR_LAST);
  assign apb_bridge_rsp.resp     = (state == BR_ERR_FIRST || state == BR_ERR_LAST) ?
                                   HRESP_ERROR : HRESP_OKAY;

endmodule

/* src/periph_top.sv */
// One AHB-Lite slave port on hclk; ready_in must be fed back from ahb_rsp.readyout by the master side
module periph_top import periph_pkg::*; #(
  parameter int APB_ADDR_W = 12
) (
  input  logic              hclk,
  input  logic              rst_n,
  input  ahb_req_t          ahb_req,
  input  logic [DATA_W-1:0] hwdata,
  input  apb_rsp_t          apb_rsp,
  output ahb_rsp_t          ahb_rsp,
  output apb_req_t          apb_req,
  output logic              timer_int
);

  logic     sel_timer;
  logic     sel_apb;
  ahb_rsp_t timer_rsp;
  ahb_rsp_t apb_bridge_rsp;

  // Region decode and response return
  ahb_slave_mux ahb_slave_mux_inst (
    .hclk           (hclk),
    .rst_n          (rst_n),
    .ahb_req        (ahb_req),
    .timer_rsp      (timer_rsp),
    .apb_bridge_rsp (apb_bridge_rsp),
    .sel_timer      (sel_timer),
    .sel_apb        (sel_apb),
    .ahb_rsp        (ahb_rsp)
  );

  ahb_timer ahb_timer_inst (
    .hclk      (hclk),
    .rst_n     (rst_n),
    .sel_timer (sel_timer),
    .ahb_req   (ahb_req),
    .hwdata    (hwdata),
    .timer_rsp (timer_rsp),
    .timer_int (timer_int)
  );

  // DMA controller APB port
  ahb_apb_bridge #(
    .APB_ADDR_W (APB_ADDR_W)
  ) ahb_apb_bridge_inst (
    .hclk           (hclk),
    .rst_n          (rst_n),
    .sel_apb        (sel_apb),
    .ahb_req        (ahb_req),
    .hwdata         (hwdata),
    .apb_rsp        (apb_rsp),
    .apb_bridge_rsp (apb_bridge_rsp),
    .apb_req        (apb_req)
  );

endmodule

/* testbench/periph_properties.sv */
// Bound into periph_top; APB handshake rules and the two-cycle AHB error, all sampled on hclk
module periph_properties import periph_pkg::*; (
  input logic     hclk,
  input logic     rst_n,
  input ahb_rsp_t ahb_rsp,
  input apb_req_t apb_req,
  input apb_rsp_t apb_rsp
);

  // psel stays up until the slave is ready
  psel_held: assert property (@(posedge hclk) disable iff (!rst_n)
    apb_req.psel && !apb_rsp.pready |=> apb_req.psel)
    else $error("psel dropped before pready");

  // Access phase only after psel was already up in setup
  penable_needs_psel: assert property (@(posedge hclk) disable iff (!rst_n)
    apb_req.penable |-> apb_req.psel && $past(apb_req.psel))
    else $error("penable high without psel held from setup");

  // Error ending with readyout high follows an error cycle with readyout low
  err_first_low: assert property (@(posedge hclk) disable iff (!rst_n)
    ahb_rsp.readyout && ahb_rsp.resp == HRESP_ERROR |->
      $past(!ahb_rsp.readyout && ahb_rsp.resp == HRESP_ERROR))
    else $error("error response did not start with readyout low");

endmodule

bind periph_top periph_properties periph_properties_inst (
  .hclk    (hclk),
  .rst_n   (rst_n),
  .ahb_rsp (ahb_rsp),
  .apb_req (apb_req),
  .apb_rsp (apb_rsp)
);

/* testbench/tb_periph.sv */
// ready_in is fed from readyout like a single-slave AHB fabric; the APB slave model errs on paddr[11]
module tb_periph import periph_pkg::*; ();

  localparam int                  BUS_TIMEOUT   = 50;
  localparam int                  INT_TIMEOUT   = 100;
  localparam logic [AHB_ADDR_W-1:0] APB_BASE      = 32'h0000_1000;
  localparam logic [AHB_ADDR_W-1:0] UNMAPPED_BASE = 32'h0000_5000;

  logic              hclk = 1'b0;
  logic              rst_n;
  ahb_req_t          ahb_req_q;
  ahb_req_t          ahb_req;
  logic [DATA_W-1:0] hwdata;
  apb_rsp_t          apb_rsp = '0;
  ahb_rsp_t          ahb_rsp;
  apb_req_t          apb_req;
  logic              timer_int;
  logic [31:0]       lcg_state = 32'h6dc9;
  logic [DATA_W-1:0] apb_mem [16];
  int                apb_wait;
  int                apb_sel_cycles = 0;

  always #5 hclk = ~hclk;

  // HREADY mux of a fabric with one slave port
  always_comb begin
    ahb_req          = ahb_req_q;
    ahb_req.ready_in = ahb_rsp.readyout;
  end

  periph_top #(
    .APB_ADDR_W (12)
  ) periph_top_inst (
    .hclk      (hclk),
    .rst_n     (rst_n),
    .ahb_req   (ahb_req),
    .hwdata    (hwdata),
    .apb_rsp   (apb_rsp),
    .ahb_rsp   (ahb_rsp),
    .apb_req   (apb_req),
    .timer_int (timer_int)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [AHB_ADDR_W-1:0] timer_addr(input timer_reg_e r);
    return {28'h0, r};
  endfunction

  // ---------------------------------------------------------------------
  // APB slave model, 0 to 3 wait cycles per transfer

  task automatic apb_drive_ready();
    apb_rsp.pready  <= 1'b1;
    apb_rsp.pslverr <= apb_req.paddr[11];
    apb_rsp.prdata  <= apb_mem[apb_req.paddr[5:2]];
  endtask

  always @(posedge hclk) begin : apb_slave_model
    logic [31:0] pick;
    if (!rst_n) begin
      apb_rsp  <= '0;
      apb_wait <= 0;
      for (int i = 0; i < 16; i++) begin
        apb_mem[i] <= 32'hC0DE_0000 ^ (i * 32'h0001_0101);
      end
    end else if (apb_rsp.pready) begin
      if (apb_req.pwrite && !apb_rsp.pslverr) begin
        apb_mem[apb_req.paddr[5:2]] <= apb_req.pwdata;
      end
      apb_rsp.pready  <= 1'b0;
      apb_rsp.pslverr <= 1'b0;
    end else if (apb_req.psel && !apb_req.penable) begin
      pick = lcg_next();
      apb_wait <= int'(pick[17:16]);
      if (pick[17:16] == 2'd0) begin
        apb_drive_ready();
      end
    end else if (apb_req.psel) begin
      if (apb_wait > 1) begin
        apb_wait <= apb_wait - 1;
      end else begin
        apb_drive_ready();
      end
    end
  end

  always @(posedge hclk) begin
    if (apb_req.psel) begin
      apb_sel_cycles <= apb_sel_cycles + 1;
    end
  end

  // ---------------------------------------------------------------------
  // Failure reporting and compare tasks

  task automatic report_failure();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    report_failure();
  endtask

  task automatic check_data(input logic [DATA_W-1:0] actual, input logic [DATA_W-1:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      report_failure();
    end
  endtask

  task automatic check_resp(input hresp_e actual, input hresp_e expected, input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s, got %s, expected %s", $time, what, actual.name(),
               expected.name());
      report_failure();
    end
  endtask

  task automatic check_bit(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s, got %b, expected %b", $time, what, actual, expected);
      report_failure();
    end
  endtask

  // ---------------------------------------------------------------------
  // AHB master, called and returning on a rising edge

  task automatic ahb_transfer(
    input  logic [AHB_ADDR_W-1:0] addr,
    input  logic                  write,
    input  logic [DATA_W-1:0]     wdata,
    output logic [DATA_W-1:0]     rdata,
    output hresp_e                resp,
    output hresp_e                wait_resp,
    output logic                  waited
  );
    int cycles;
    ahb_req_q.sel   <= 1'b1;
    ahb_req_q.addr  <= addr;
    ahb_req_q.trans <= HTRANS_NONSEQ;
    ahb_req_q.write <= write;
    ahb_req_q.size  <= 3'd2;
    cycles = 0;
    @(negedge hclk);
    while (!ahb_rsp.readyout) begin
      cycles++;
      if (cycles > BUS_TIMEOUT) report_timeout("address phase acceptance");
      @(negedge hclk);
    end
    @(posedge hclk);
    // Data phase
    ahb_req_q.sel   <= 1'b0;
    ahb_req_q.trans <= HTRANS_IDLE;
    hwdata          <= wdata;
    waited    = 1'b0;
    wait_resp = HRESP_OKAY;
    cycles    = 0;
    @(negedge hclk);
    while (!ahb_rsp.readyout) begin
      waited    = 1'b1;
      wait_resp = ahb_rsp.resp;
      cycles++;
      if (cycles > BUS_TIMEOUT) report_timeout("end of data phase");
      @(negedge hclk);
    end
    rdata = ahb_rsp.rdata;
    resp  = ahb_rsp.resp;
    @(posedge hclk);
  endtask

  task automatic ahb_write(input logic [AHB_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] rd;
    hresp_e            resp;
    hresp_e            wait_resp;
    logic              waited;
    ahb_transfer(addr, 1'b1, data, rd, resp, wait_resp, waited);
    check_resp(resp, HRESP_OKAY, "write response");
  endtask

  task automatic ahb_read(input logic [AHB_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    hresp_e resp;
    hresp_e wait_resp;
    logic   waited;
    ahb_transfer(addr, 1'b0, '0, data, resp, wait_resp, waited);
    check_resp(resp, HRESP_OKAY, "read response");
  endtask

  // ---------------------------------------------------------------------
  // Directed tests

  task automatic test_reset_values();
    @(negedge hclk);
    check_bit(ahb_rsp.readyout, 1'b1, "readyout after reset");
    check_resp(ahb_rsp.resp, HRESP_OKAY, "resp after reset");
    check_bit(apb_req.psel, 1'b0, "psel after reset");
    check_bit(apb_req.penable, 1'b0, "penable after reset");
    check_bit(timer_int, 1'b0, "timer_int after reset");
    @(posedge hclk);
  endtask

  task automatic test_apb_round_trip();
    logic [DATA_W-1:0] words [8];
    logic [DATA_W-1:0] rd;
    for (int i = 0; i < 8; i++) begin
      words[i] = lcg_next();
      ahb_write(APB_BASE + 32'(4 * i), words[i]);
    end
    for (int i = 0; i < 8; i++) begin
      ahb_read(APB_BASE + 32'(4 * i), rd);
      check_data(rd, words[i], "APB read back");
      check_data(apb_mem[i], words[i], "APB model memory");
    end
  endtask

  task automatic test_apb_error();
    logic [DATA_W-1:0] rd;
    hresp_e            resp;
    hresp_e            wait_resp;
    logic              waited;
    for (int w = 0; w < 2; w++) begin
      ahb_transfer(APB_BASE + 32'h804, w[0], 32'h1111_2222, rd, resp, wait_resp, waited);
      check_bit(waited, 1'b1, "APB slave error stalls first");
      check_resp(wait_resp, HRESP_ERROR, "APB slave error first cycle");
      check_resp(resp, HRESP_ERROR, "APB slave error last cycle");
    end
  endtask

  task automatic test_unmapped();
    logic [DATA_W-1:0] value_before;
    logic [DATA_W-1:0] reload_before;
    logic [DATA_W-1:0] rd;
    hresp_e            resp;
    hresp_e            wait_resp;
    logic              waited;
    int                sel_before;
    ahb_read(timer_addr(TREG_VALUE), value_before);
    ahb_read(timer_addr(TREG_RELOAD), reload_before);
    sel_before = apb_sel_cycles;
    // Offsets of the timer value and reload registers
    for (int off = 4; off <= 8; off += 4) begin
      ahb_transfer(UNMAPPED_BASE + 32'(off), 1'b1, 32'hDEAD_BEEF,
                   rd, resp, wait_resp, waited);
      check_bit(waited, 1'b1, "unmapped access stalls first");
      check_resp(wait_resp, HRESP_ERROR, "unmapped first cycle");
      check_resp(resp, HRESP_ERROR, "unmapped last cycle");
    end
    check_bit(apb_sel_cycles == sel_before, 1'b1, "APB port idle during unmapped access");
    ahb_read(timer_addr(TREG_VALUE), rd);
    check_data(rd, value_before, "timer value after unmapped write");
    ahb_read(timer_addr(TREG_RELOAD), rd);
    check_data(rd, reload_before, "timer reload after unmapped write");
  endtask

  task automatic test_timer_regs();
    logic [DATA_W-1:0] rd;
    ahb_write(timer_addr(TREG_CTRL), 32'h0);
    ahb_write(timer_addr(TREG_VALUE), 32'h1234_5678);
    ahb_write(timer_addr(TREG_RELOAD), 32'h0BAD_F00D);
    ahb_read(timer_addr(TREG_VALUE), rd);
    check_data(rd, 32'h1234_5678, "timer value read back");
    ahb_read(timer_addr(TREG_RELOAD), rd);
    check_data(rd, 32'h0BAD_F00D, "timer reload read back");
    ahb_write(timer_addr(TREG_CTRL), 32'hFFFF_FFFF);
    ahb_read(timer_addr(TREG_CTRL), rd);
    check_data(rd, 32'h0000_0003, "timer ctrl keeps two bits");
    ahb_write(timer_addr(TREG_CTRL), 32'h0);
  endtask

  task automatic test_timer_interrupt();
    logic [DATA_W-1:0] rd;
    int                cycles;
    ahb_write(timer_addr(TREG_RELOAD), 32'd20);
    ahb_write(timer_addr(TREG_VALUE), 32'd5);
    ahb_write(timer_addr(TREG_CTRL), 32'h3);
    cycles = 0;
    @(negedge hclk);
    while (!timer_int) begin
      cycles++;
      if (cycles > INT_TIMEOUT) report_timeout("timer interrupt");
      @(negedge hclk);
    end
    @(posedge hclk);
    ahb_read(timer_addr(TREG_STATUS), rd);
    check_data(rd, 32'h1, "timer status flag");
    ahb_write(timer_addr(TREG_STATUS), 32'h1);
    @(negedge hclk);
    check_bit(timer_int, 1'b0, "timer_int after status clear");
    @(posedge hclk);
    ahb_read(timer_addr(TREG_VALUE), rd);
    check_bit(rd <= 32'd20, 1'b1, "timer count within reload");
    ahb_write(timer_addr(TREG_CTRL), 32'h0);
  endtask

  initial begin
    rst_n     = 1'b0;
    ahb_req_q = '0;
    hwdata    = '0;
    repeat (3) @(posedge hclk);
    rst_n <= 1'b1;
    @(posedge hclk);
    test_reset_values();
    test_apb_round_trip();
    test_apb_error();
    test_unmapped();
    test_timer_regs();
    test_timer_interrupt();
    $display("Test passed");
    $finish;
  end

endmodule

/* tb.f */
common/periph_pkg.sv
src/ahb_slave_mux.sv
timer/ahb_timer.sv
apb_bridge/ahb_apb_bridge.sv
src/periph_top.sv
testbench/periph_properties.sv
testbench/tb_periph.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_periph
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
